// File: source/rob_params.svh
// reorder buffer widths and counts, included by every RTL and testbench file that sizes a port
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// rob index width, depth is 2**index
`define ROB_INDEX_W 5

// number of rob entries
`define ROB_DEPTH 32

// width of a result value and of a pc
`define ROB_DATA_W 32

// architectural register index
`define ROB_REG_W 5

// alu broadcast ports into the rob
`define ROB_WB_PORTS 2

`endif

// File: source/rob_pkg.sv
// reorder buffer types, referenced by scoped name from RTL and testbench
`include "rob_params.svh"

package rob_pkg;

    // instruction kind, given by the scheduler at issue
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_IMM    = 2'd1,
        KIND_STORE  = 2'd2,
        KIND_BRANCH = 2'd3
    } rob_kind_e;

    // rob entry index
    typedef logic [`ROB_INDEX_W-1:0] rob_idx_t;

    // result value or pc
    typedef logic [`ROB_DATA_W-1:0] rob_data_t;

    // architectural destination register
    typedef logic [`ROB_REG_W-1:0] rob_reg_t;

endpackage

// File: source/rob_ptr_ctrl.sv
// head, tail and occupancy of the reorder buffer queue, instantiated by rob_top
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_ptr_ctrl (
    input  logic              clk,
    input  logic              reset_broadcast,
    input  logic              issue,
    input  logic              commit,
    input  logic              flush_all,
    output rob_pkg::rob_idx_t head_idx,
    output rob_pkg::rob_idx_t tail_idx,
    output logic              full,
    output logic              empty
);

    // 0 to ROB_DEPTH, one bit wider than an index
    logic [`ROB_INDEX_W:0] count;

    logic issue_ok;

    // issue is dropped while full or during the flush cycle
    assign issue_ok = issue && !full && !flush_all;

    always_ff @(posedge clk) begin
        if (reset_broadcast || flush_all) begin
            tail_idx <= '0;
        end else if (issue_ok) begin
            tail_idx <= rob_pkg::rob_idx_t'(tail_idx + 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_broadcast || flush_all) begin
            head_idx <= '0;
        end else if (commit) begin
            head_idx <= rob_pkg::rob_idx_t'(head_idx + 1'b1);
        end
    end

    // occupancy, unchanged when issue and commit meet
    always_ff @(posedge clk) begin
        if (reset_broadcast || flush_all) begin
            count <= '0;
        end else begin
            case ({issue_ok, commit})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign full  = (count == (`ROB_INDEX_W+1)'(`ROB_DEPTH));
    assign empty = (count == '0);

endmodule

// File: source/rob_entry_table.sv
// reorder buffer entry storage, written by issue and the completion ports, read at the head
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_entry_table (
    input  logic                clk,
    input  logic                reset_broadcast,

    input  logic                issue_we,
    input  rob_pkg::rob_idx_t   tail_idx,
    input  rob_pkg::rob_reg_t   issue_dr,
    input  rob_pkg::rob_kind_e  issue_kind,
    input  rob_pkg::rob_data_t  issue_imm_val,

    input  logic [`ROB_WB_PORTS-1:0] wb_valid,
    input  rob_pkg::rob_idx_t   wb_rob_idx [`ROB_WB_PORTS],
    input  rob_pkg::rob_data_t  wb_value [`ROB_WB_PORTS],

    input  logic                ld_valid,
    input  rob_pkg::rob_idx_t   ld_rob_idx,
    input  rob_pkg::rob_data_t  ld_value,
    input  logic                ld_is_st,

    input  logic                br_valid,
    input  rob_pkg::rob_idx_t   br_rob_idx,
    input  logic                br_mispredict,
    input  rob_pkg::rob_data_t  br_target_pc,

    input  logic                commit_we,
    input  rob_pkg::rob_idx_t   head_idx,
    input  logic                flush_all,

    output logic                head_valid,
    output logic                head_done,
    output rob_pkg::rob_kind_e  head_kind,
    output rob_pkg::rob_reg_t   head_dr,
    output rob_pkg::rob_data_t  head_value,
    output logic                head_mispredict,
    output rob_pkg::rob_data_t  head_target,
    output logic                br_in_rob
);

    logic               entry_valid      [`ROB_DEPTH];
    logic               entry_done       [`ROB_DEPTH];
    rob_pkg::rob_kind_e entry_kind       [`ROB_DEPTH];
    rob_pkg::rob_reg_t  entry_dr         [`ROB_DEPTH];
    rob_pkg::rob_data_t entry_value      [`ROB_DEPTH];
    logic               entry_mispredict [`ROB_DEPTH];
    rob_pkg::rob_data_t entry_target     [`ROB_DEPTH];

    // valid bits, cleared by reset and by a flush
    always_ff @(posedge clk) begin
        if (reset_broadcast || flush_all) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else begin
            if (issue_we) begin
                entry_valid[tail_idx] <= 1'b1;
            end
            if (commit_we) begin
                entry_valid[head_idx] <= 1'b0;
            end
        end
    end

    // entry contents, only meaningful while valid
    always_ff @(posedge clk) begin
        if (issue_we) begin
            entry_kind[tail_idx]       <= issue_kind;
            entry_dr[tail_idx]         <= issue_dr;
            entry_value[tail_idx]      <= issue_imm_val;
            entry_mispredict[tail_idx] <= 1'b0;
            // immediate loads need no execution
            entry_done[tail_idx]       <= (issue_kind == rob_pkg::KIND_IMM);
        end

        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            if (wb_valid[p]) begin
                entry_done[wb_rob_idx[p]]  <= 1'b1;
                entry_value[wb_rob_idx[p]] <= wb_value[p];
            end
        end

        if (ld_valid) begin
            entry_done[ld_rob_idx] <= 1'b1;
            // stores carry no result
            if (!ld_is_st) begin
                entry_value[ld_rob_idx] <= ld_value;
            end
        end

        if (br_valid) begin
            entry_done[br_rob_idx]       <= 1'b1;
            entry_mispredict[br_rob_idx] <= br_mispredict;
            entry_target[br_rob_idx]     <= br_target_pc;
        end
    end

    // any unretired branch
    always_comb begin
        br_in_rob = 1'b0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (entry_valid[i] && entry_kind[i] == rob_pkg::KIND_BRANCH) begin
                br_in_rob = 1'b1;
            end
        end
    end

    // head read port
    assign head_valid      = entry_valid[head_idx];
    assign head_done       = entry_done[head_idx];
    assign head_kind       = entry_kind[head_idx];
    assign head_dr         = entry_dr[head_idx];
    assign head_value      = entry_value[head_idx];
    assign head_mispredict = entry_mispredict[head_idx];
    assign head_target     = entry_target[head_idx];

endmodule

// File: source/rob_commit_unit.sv
// combinational decode of the head entry into commit, register write and flush
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_commit_unit (
    input  logic               head_valid,
    input  logic               head_done,
    input  rob_pkg::rob_kind_e head_kind,
    input  rob_pkg::rob_reg_t  head_dr,
    input  rob_pkg::rob_data_t head_value,
    input  logic               head_mispredict,
    input  rob_pkg::rob_data_t head_target,
    input  rob_pkg::rob_idx_t  head_idx,
    output logic               commit_ready,
    output logic               regfile_valid,
    output rob_pkg::rob_reg_t  regfile_idx,
    output rob_pkg::rob_idx_t  regfile_rob_idx,
    output rob_pkg::rob_data_t regfile_value,
    output logic               flush_all,
    output rob_pkg::rob_data_t target_pc
);

    logic head_finished;
    logic head_is_branch;
    logic head_writes_reg;

    assign head_finished   = head_valid && head_done;
    assign head_is_branch  = (head_kind == rob_pkg::KIND_BRANCH);
    assign head_writes_reg = (head_kind == rob_pkg::KIND_ALU) ||
                             (head_kind == rob_pkg::KIND_IMM);

    // a mispredicted branch never retires, it flushes instead
    assign commit_ready = head_finished && !(head_is_branch && head_mispredict);

    // stores and correct branches retire without a write
    assign regfile_valid   = commit_ready && head_writes_reg;
    assign regfile_idx     = head_dr;
    assign regfile_rob_idx = head_idx;
    assign regfile_value   = head_value;

    // queue empties on the next edge, so this lasts one cycle
    assign flush_all = head_finished && head_is_branch && head_mispredict;
    assign target_pc = head_target;

endmodule

// File: source/rob_top.sv
// reorder buffer top level, connects pointer control, entry table and commit decode
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_top (
    input  logic                     clk,
    input  logic                     reset_broadcast,

    input  logic                     issue,
    input  rob_pkg::rob_reg_t        issue_dr,
    input  rob_pkg::rob_kind_e       issue_kind,
    input  rob_pkg::rob_data_t       issue_imm_val,
    output rob_pkg::rob_idx_t        issue_rob_idx,
    output logic                     full,
    output logic                     empty,

    input  logic [`ROB_WB_PORTS-1:0] wb_valid,
    input  rob_pkg::rob_idx_t        wb_rob_idx [`ROB_WB_PORTS],
    input  rob_pkg::rob_data_t       wb_value [`ROB_WB_PORTS],

    input  logic                     ld_valid,
    input  rob_pkg::rob_idx_t        ld_rob_idx,
    input  rob_pkg::rob_data_t       ld_value,
    input  logic                     ld_is_st,

    input  logic                     br_valid,
    input  rob_pkg::rob_idx_t        br_rob_idx,
    input  logic                     br_mispredict,
    input  rob_pkg::rob_data_t       br_target_pc,

    input  logic                     commit,
    output logic                     commit_ready,
    output logic                     regfile_valid,
    output rob_pkg::rob_reg_t        regfile_idx,
    output rob_pkg::rob_idx_t        regfile_rob_idx,
    output rob_pkg::rob_data_t       regfile_value,
    output logic                     flush_all,
    output rob_pkg::rob_data_t       target_pc,
    output logic                     br_in_rob
);

    rob_pkg::rob_idx_t  head_idx;
    rob_pkg::rob_idx_t  tail_idx;
    logic               issue_we;
    logic               commit_we;

    logic               head_valid;
    logic               head_done;
    rob_pkg::rob_kind_e head_kind;
    rob_pkg::rob_reg_t  head_dr;
    rob_pkg::rob_data_t head_value;
    logic               head_mispredict;
    rob_pkg::rob_data_t head_target;

    assign issue_we  = issue && !full && !flush_all;
    assign commit_we = commit && commit_ready && !empty;

    // scheduler tags the next issue with the tail
    assign issue_rob_idx = tail_idx;

    rob_ptr_ctrl u_ptr_ctrl (
        .clk             (clk),
        .reset_broadcast (reset_broadcast),
        .issue           (issue),
        .commit          (commit_we),
        .flush_all       (flush_all),
        .head_idx        (head_idx),
        .tail_idx        (tail_idx),
        .full            (full),
        .empty           (empty)
    );

    rob_entry_table u_entry_table (
        .clk             (clk),
        .reset_broadcast (reset_broadcast),
        .issue_we        (issue_we),
        .tail_idx        (tail_idx),
        .issue_dr        (issue_dr),
        .issue_kind      (issue_kind),
        .issue_imm_val   (issue_imm_val),
        .wb_valid        (wb_valid),
        .wb_rob_idx      (wb_rob_idx),
        .wb_value        (wb_value),
        .ld_valid        (ld_valid),
        .ld_rob_idx      (ld_rob_idx),
        .ld_value        (ld_value),
        .ld_is_st        (ld_is_st),
        .br_valid        (br_valid),
        .br_rob_idx      (br_rob_idx),
        .br_mispredict   (br_mispredict),
        .br_target_pc    (br_target_pc),
        .commit_we       (commit_we),
        .head_idx        (head_idx),
        .flush_all       (flush_all),
        .head_valid      (head_valid),
        .head_done       (head_done),
        .head_kind       (head_kind),
        .head_dr         (head_dr),
        .head_value      (head_value),
        .head_mispredict (head_mispredict),
        .head_target     (head_target),
        .br_in_rob       (br_in_rob)
    );

    rob_commit_unit u_commit_unit (
        .head_valid      (head_valid),
        .head_done       (head_done),
        .head_kind       (head_kind),
        .head_dr         (head_dr),
        .head_value      (head_value),
        .head_mispredict (head_mispredict),
        .head_target     (head_target),
        .head_idx        (head_idx),
        .commit_ready    (commit_ready),
        .regfile_valid   (regfile_valid),
        .regfile_idx     (regfile_idx),
        .regfile_rob_idx (regfile_rob_idx),
        .regfile_value   (regfile_value),
        .flush_all       (flush_all),
        .target_pc       (target_pc)
    );

endmodule

// File: dv/rob_checker.sv
// concurrent protocol assertions for the reorder buffer, bound into every rob_top instance
`timescale 1ns/1ns

module rob_checker (
    input logic clk,
    input logic reset_broadcast,
    input logic issue,
    input logic full,
    input logic empty,
    input logic flush_all
);

    // scheduler holds issue while the buffer is full
    issue_not_when_full: assert property (
        @(posedge clk) disable iff (reset_broadcast) !(issue && full)
    ) else $error("issue strobe while the reorder buffer is full");

    full_not_with_empty: assert property (
        @(posedge clk) disable iff (reset_broadcast) !(full && empty)
    ) else $error("full and empty are high together");

    // the queue is cleared at the next edge, so no second flush cycle
    flush_single_cycle: assert property (
        @(posedge clk) disable iff (reset_broadcast) flush_all |=> !flush_all
    ) else $error("flush_all stayed high for two cycles");

    flush_then_empty: assert property (
        @(posedge clk) disable iff (reset_broadcast) flush_all |=> empty
    ) else $error("buffer not empty in the cycle after flush_all");

endmodule

bind rob_top rob_checker u_checker (
    .clk             (clk),
    .reset_broadcast (reset_broadcast),
    .issue           (issue),
    .full            (full),
    .empty           (empty),
    .flush_all       (flush_all)
);

// File: dv/rob_tb.sv
// random testbench for the reorder buffer, drives rob_top and checks it against a queue model
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_tb;

    localparam int DEPTH       = `ROB_DEPTH;
    localparam int PORTS       = `ROB_WB_PORTS;
    localparam int RAND_CYCLES = 3000;
    localparam int WAIT_LIMIT  = 2000;

    logic               clk;
    logic               reset_broadcast;
    logic               issue;
    rob_pkg::rob_reg_t  issue_dr;
    rob_pkg::rob_kind_e issue_kind;
    rob_pkg::rob_data_t issue_imm_val;
    rob_pkg::rob_idx_t  issue_rob_idx;
    logic               full, empty;
    logic [PORTS-1:0]   wb_valid;
    rob_pkg::rob_idx_t  wb_rob_idx [PORTS];
    rob_pkg::rob_data_t wb_value [PORTS];
    logic               ld_valid, ld_is_st;
    rob_pkg::rob_idx_t  ld_rob_idx;
    rob_pkg::rob_data_t ld_value;
    logic               br_valid, br_mispredict;
    rob_pkg::rob_idx_t  br_rob_idx;
    rob_pkg::rob_data_t br_target_pc;
    logic               commit, commit_ready, regfile_valid, flush_all, br_in_rob;
    rob_pkg::rob_reg_t  regfile_idx;
    rob_pkg::rob_idx_t  regfile_rob_idx;
    rob_pkg::rob_data_t regfile_value, target_pc;

    // model state, one slot per rob entry
    logic               m_valid [DEPTH];
    logic               m_done [DEPTH];
    logic               m_misp [DEPTH];
    rob_pkg::rob_kind_e m_kind [DEPTH];
    rob_pkg::rob_reg_t  m_dr [DEPTH];
    rob_pkg::rob_data_t m_value [DEPTH];
    rob_pkg::rob_data_t m_target [DEPTH];
    rob_pkg::rob_idx_t  m_head, m_tail;
    int                 m_count;
    int                 errors, checks, commits, flushes;

    rob_top DUT (.*);

    always #20 clk = ~clk;

    function automatic logic head_flush();
        return m_valid[m_head] && m_done[m_head] && m_misp[m_head] &&
               m_kind[m_head] == rob_pkg::KIND_BRANCH;
    endfunction

    function automatic logic head_ready();
        return m_valid[m_head] && m_done[m_head] && !head_flush();
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_outputs();
        logic writes;
        logic any_branch;
        any_branch = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i] && m_kind[i] == rob_pkg::KIND_BRANCH) begin
                any_branch = 1'b1;
            end
        end
        writes = head_ready() &&
                 m_kind[m_head] inside {rob_pkg::KIND_ALU, rob_pkg::KIND_IMM};
        check_value("empty", 32'(m_count == 0), 32'(empty));
        check_value("full", 32'(m_count == DEPTH), 32'(full));
        check_value("issue_rob_idx", 32'(m_tail), 32'(issue_rob_idx));
        check_value("commit_ready", 32'(head_ready()), 32'(commit_ready));
        check_value("regfile_valid", 32'(writes), 32'(regfile_valid));
        check_value("flush_all", 32'(head_flush()), 32'(flush_all));
        check_value("br_in_rob", 32'(any_branch), 32'(br_in_rob));
        if (writes) begin
            check_value("regfile_idx", 32'(m_dr[m_head]), 32'(regfile_idx));
            check_value("regfile_rob_idx", 32'(m_head), 32'(regfile_rob_idx));
            check_value("regfile_value", m_value[m_head], regfile_value);
        end
        if (head_flush()) begin
            check_value("target_pc", m_target[m_head], target_pc);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i]  = 1'b0;
            m_done[i]   = 1'b0;
            m_misp[i]   = 1'b0;
            m_kind[i]   = rob_pkg::KIND_ALU;
            m_dr[i]     = '0;
            m_value[i]  = '0;
            m_target[i] = '0;
        end
        m_head  = '0;
        m_tail  = '0;
        m_count = 0;
    endtask

    task automatic drive_inputs(input int issue_pct, input bit allow_done, input bit allow_commit);
        int                 start;
        int                 port;
        rob_pkg::rob_idx_t  idx;
        rob_pkg::rob_kind_e kind;
        issue    = 1'b0;
        wb_valid = '0;
        ld_valid = 1'b0;
        ld_is_st = 1'b0;
        br_valid = 1'b0;
        commit   = 1'b0;
        if (m_count < DEPTH && $urandom_range(0, 99) < issue_pct) begin
            issue         = 1'b1;
            issue_dr      = rob_pkg::rob_reg_t'($urandom_range(0, 31));
            issue_kind    = rob_pkg::rob_kind_e'($urandom_range(0, 3));
            issue_imm_val = $urandom;
        end
        // pending entries complete in random order, at most one strobe each
        start = $urandom_range(0, DEPTH - 1);
        for (int i = 0; i < DEPTH; i++) begin
            idx  = rob_pkg::rob_idx_t'(start + i);
            kind = m_kind[idx];
            port = $urandom_range(0, PORTS + 1);
            if (allow_done && m_valid[idx] && !m_done[idx] && $urandom_range(0, 2) == 0) begin
                if (kind == rob_pkg::KIND_BRANCH && !br_valid) begin
                    br_valid      = 1'b1;
                    br_rob_idx    = idx;
                    br_mispredict = ($urandom_range(0, 5) == 0);
                    br_target_pc  = $urandom;
                end else if (kind != rob_pkg::KIND_BRANCH && port >= PORTS && !ld_valid) begin
                    ld_valid   = 1'b1;
                    ld_is_st   = (kind == rob_pkg::KIND_STORE);
                    ld_rob_idx = idx;
                    ld_value   = $urandom;
                end else if (kind == rob_pkg::KIND_ALU && port < PORTS && !wb_valid[port]) begin
                    wb_valid[port]   = 1'b1;
                    wb_rob_idx[port] = idx;
                    wb_value[port]   = $urandom;
                end
            end
        end
        if (allow_commit && head_ready() && $urandom_range(0, 9) < 7) begin
            commit = 1'b1;
        end
    endtask

    // applies the strobes that were sampled at this rising edge
    task automatic update_model();
        logic ready;
        ready = head_ready();
        if (head_flush()) begin
            flushes++;
            clear_model();
        end else begin
            if (issue && m_count < DEPTH) begin
                m_valid[m_tail] = 1'b1;
                m_done[m_tail]  = (issue_kind == rob_pkg::KIND_IMM);
                m_misp[m_tail]  = 1'b0;
                m_kind[m_tail]  = issue_kind;
                m_dr[m_tail]    = issue_dr;
                m_value[m_tail] = issue_imm_val;
                m_tail          = m_tail + 1'b1;
                m_count++;
            end
            for (int p = 0; p < PORTS; p++) begin
                if (wb_valid[p]) begin
                    m_done[wb_rob_idx[p]]  = 1'b1;
                    m_value[wb_rob_idx[p]] = wb_value[p];
                end
            end
            if (ld_valid) begin
                m_done[ld_rob_idx] = 1'b1;
                if (!ld_is_st) begin
                    m_value[ld_rob_idx] = ld_value;
                end
            end
            if (br_valid) begin
                m_done[br_rob_idx]   = 1'b1;
                m_misp[br_rob_idx]   = br_mispredict;
                m_target[br_rob_idx] = br_target_pc;
            end
            if (commit && ready) begin
                m_valid[m_head] = 1'b0;
                m_head          = m_head + 1'b1;
                m_count--;
                commits++;
            end
        end
    endtask

    task automatic step(input int issue_pct, input bit allow_done, input bit allow_commit);
        @(negedge clk);
        check_outputs();
        drive_inputs(issue_pct, allow_done, allow_commit);
        @(posedge clk);
        update_model();
    endtask

    task automatic run_until_count(input int target, input int issue_pct,
                                   input bit allow_done, input bit allow_commit);
        int cycles;
        cycles = 0;
        while (m_count != target && cycles < WAIT_LIMIT) begin
            step(issue_pct, allow_done, allow_commit);
            cycles++;
        end
        if (m_count != target) begin
            errors++;
            $display("timeout: occupancy stuck at %0d, expected it to reach %0d", m_count, target);
        end
    endtask

    initial begin
        void'($urandom(32'heb1c));
        clk             = 1'b0;
        reset_broadcast = 1'b1;
        issue           = 1'b0;
        issue_dr        = '0;
        issue_kind      = rob_pkg::KIND_ALU;
        issue_imm_val   = '0;
        wb_valid        = '0;
        for (int p = 0; p < PORTS; p++) begin
            wb_rob_idx[p] = '0;
            wb_value[p]   = '0;
        end
        ld_valid        = 1'b0;
        ld_is_st        = 1'b0;
        ld_rob_idx      = '0;
        ld_value        = '0;
        br_valid        = 1'b0;
        br_mispredict   = 1'b0;
        br_rob_idx      = '0;
        br_target_pc    = '0;
        commit          = 1'b0;
        errors          = 0;
        checks          = 0;
        commits         = 0;
        flushes         = 0;
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_broadcast = 1'b0;

        // fill with no completions so the tail wraps, then retire everything
        run_until_count(DEPTH, 100, 1'b0, 1'b0);
        run_until_count(0, 0, 1'b1, 1'b1);
        repeat (RAND_CYCLES) begin
            step(60, 1'b1, 1'b1);
        end
        run_until_count(0, 0, 1'b1, 1'b1);
        step(0, 1'b0, 1'b0);
        if (flushes == 0) begin
            errors++;
            $display("no mispredicted branch ever flushed the buffer");
        end

        $display("checks %0d errors %0d commits %0d flushes %0d", checks, errors, commits, flushes);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/rob_pkg.sv
source/rob_ptr_ctrl.sv
source/rob_entry_table.sv
source/rob_commit_unit.sv
source/rob_top.sv
dv/rob_checker.sv
dv/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard source/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
